/* hdl/rgb_pkg.sv */
package rgb_pkg;

    // frame geometry
    localparam int IMAGE_W = 80;
    localparam int IMAGE_H = 48;
    localparam int IMAGE_SIZE = IMAGE_W * IMAGE_H;    // 3840 pixels per frame

    localparam int IMAGE_IN_RAM = 3;                  // frames held in the buffer
    localparam int RAM_DEPTH = IMAGE_SIZE * IMAGE_IN_RAM;

    // frames stored before playback may start
    localparam int SLICES_BEFORE_STREAM = 1;

    // one RAM word, seen either raw or split into its colour fields
    typedef union packed {
        logic [15:0] raw;                             // what the RAM stores
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } ch;
    } pixel565_u;

    // spi command bytes
    localparam logic [7:0] CMD_DISABLE = 8'h00;
    localparam logic [7:0] CMD_ENABLE = 8'h01;

    // flag positions in the status byte, other bits read as zero
    localparam int STATUS_BIT_READY = 7;
    localparam int STATUS_BIT_ENABLE = 6;

endpackage

/* hdl/rgb_logic.sv */
module rgb_logic
    import rgb_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 32
) (
    input  logic                      rgb_clk,
    input  logic                      nrst,
    input  logic [23:0]               rgb,          // only the top bits of each channel are kept
    input  logic                      hsync,        // active low
    input  logic                      vsync,        // active low
    input  logic                      rgb_enable,   // capture on/off from spi
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr,
    output pixel565_u                 ram_data,
    output logic                      write_enable,
    output logic                      stream_ready  // enough frames stored to start display
);

    logic        blanking;
    logic        is_end_of_ram;
    logic        is_valid_first_frame;
    logic        advance;
    logic [31:0] pixel_counter;

    assign blanking = ~hsync | ~vsync;    // either sync low means no pixel
    assign is_end_of_ram = (ram_addr == RAM_ADDR_WIDTH'(RAM_DEPTH - 1));

    // capture may be switched on mid frame
    // so counting waits for vsync high or an already full first frame
    assign is_valid_first_frame = vsync | (pixel_counter >= 32'(IMAGE_SIZE - 1));

    assign advance = rgb_enable & is_valid_first_frame;

    // truncate to 5/6/5
    always_comb begin
        ram_data.ch.red = rgb[23:19];
        ram_data.ch.green = rgb[15:10];
        ram_data.ch.blue = rgb[7:3];
    end

    assign write_enable = ~blanking & rgb_enable;

    // address moves on the falling edge so the ram sees a stable address at the rising edge
    always_ff @(negedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            ram_addr <= '0;
        end else if (advance) begin
            if (!blanking && !is_end_of_ram)
                ram_addr <= ram_addr + 1'b1;    // next pixel slot
        end else begin
            ram_addr <= '0;                     // capture off or partial frame dropped
        end
    end
    // note at the last location the address sticks and keeps being overwritten

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            pixel_counter <= '0;
        end else if (advance) begin
            if (!blanking)
                pixel_counter <= pixel_counter + 1'b1;
        end else begin
            pixel_counter <= '0;    // restart so a real frame start is awaited
        end
    end

    // sticky until capture goes off
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            stream_ready <= 1'b0;
        end else if (!rgb_enable) begin
            stream_ready <= 1'b0;
        end else if (pixel_counter >= 32'(SLICES_BEFORE_STREAM * IMAGE_SIZE)) begin
            stream_ready <= 1'b1;
        end
    end

    addr_in_range: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        ram_addr <= RAM_ADDR_WIDTH'(RAM_DEPTH - 1)
    );

    // ready must drop the cycle after capture is switched off
    ready_follows_enable: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        !rgb_enable |=> !stream_ready
    );

endmodule

/* hdl/spi_ctrl.sv */
module spi_ctrl
    import rgb_pkg::*;
(
    input  logic rgb_clk,
    input  logic nrst,
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    input  logic stream_ready,
    output logic miso,
    output logic rgb_enable
);

    logic [2:0] sclk_q;    // two sync stages plus one for edge detect
    logic [2:0] cs_q;
    logic [1:0] mosi_q;    // same age as sclk_q[1]
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_rise;
    logic       cs_fall;
    logic       cs_active;
    logic [3:0] bit_cnt;
    logic       bit_ovf;   // more than 8 clocks seen in this transfer
    logic [1:0] cmd_pipe;  // delays the command strobe
    logic [7:0] cmd_shift;
    logic [7:0] cmd_byte;
    logic [7:0] status_byte;
    logic [7:0] status_shift;

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_rise = cs_q[1] & ~cs_q[2];
    assign cs_fall = ~cs_q[1] & cs_q[2];
    assign cs_active = ~cs_q[1];

    always_comb begin
        status_byte = '0;
        status_byte[STATUS_BIT_READY] = stream_ready;
        status_byte[STATUS_BIT_ENABLE] = rgb_enable;
    end

    assign miso = status_shift[7];    // msb first

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            sclk_q <= '0;
            cs_q <= '1;    // idle deselected
            mosi_q <= '0;
            bit_cnt <= '0;
            bit_ovf <= 1'b0;
            cmd_pipe <= '0;
            rgb_enable <= 1'b0;
        end else begin
            sclk_q <= {sclk_q[1:0], sclk};
            cs_q <= {cs_q[1:0], cs_n};
            mosi_q <= {mosi_q[0], mosi};
            if (cs_fall) begin
                bit_cnt <= '0;
                bit_ovf <= 1'b0;
            end else if (cs_active && sclk_rise) begin
                if (bit_cnt == 4'd8)
                    bit_ovf <= 1'b1;    // counter holds, transfer is rejected
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
            cmd_pipe <= {cmd_pipe[0], cs_rise & (bit_cnt == 4'd8) & ~bit_ovf};
            if (cmd_pipe[1]) begin
                if (cmd_byte == CMD_ENABLE)
                    rgb_enable <= 1'b1;
                else if (cmd_byte == CMD_DISABLE)
                    rgb_enable <= 1'b0;
                // unknown bytes leave the state alone
            end
        end
    end

    always_ff @(posedge rgb_clk) begin
        if (cs_active && sclk_rise)
            cmd_shift <= {cmd_shift[6:0], mosi_q[1]};
        if (cs_rise)
            cmd_byte <= cmd_shift;
        if (cs_fall)
            status_shift <= status_byte;                 // snapshot at select
        else if (cs_active && sclk_fall)
            status_shift <= {status_shift[6:0], 1'b0};   // master samples on rise
    end

    bit_cnt_bound: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        cs_active |-> bit_cnt <= 4'd8
    );

endmodule

/* hdl/frame_ram.sv */
module frame_ram
    import rgb_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 32
) (
    input  logic                      rgb_clk,
    input  logic                      wr_en,
    input  logic [RAM_ADDR_WIDTH-1:0] wr_addr,
    input  pixel565_u                 wr_data,
    input  logic                      rd_en,
    input  logic [RAM_ADDR_WIDTH-1:0] rd_addr,
    output pixel565_u                 rd_data
);

    logic [15:0] mem [RAM_DEPTH];    // three frames of rgb565

    // write port
    always_ff @(posedge rgb_clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data.raw;
    end

    // registered read, one cycle latency
    always_ff @(posedge rgb_clk) begin
        if (rd_en)
            rd_data.raw <= mem[rd_addr];
    end

    // both address generators must stay inside the buffer
    addr_below_depth: assert property (
        @(posedge rgb_clk)
        (wr_en |-> wr_addr < RAM_ADDR_WIDTH'(RAM_DEPTH)) and
        (rd_en |-> rd_addr < RAM_ADDR_WIDTH'(RAM_DEPTH))
    );

endmodule

/* hdl/stream_reader.sv */
module stream_reader
    import rgb_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 32
) (
    input  logic                      rgb_clk,
    input  logic                      nrst,
    input  logic                      stream_ready,
    input  logic                      pix_req,      // one cycle strobe from the display
    output logic                      rd_en,
    output logic [RAM_ADDR_WIDTH-1:0] rd_addr,
    input  pixel565_u                 rd_data,
    output logic                      pix_valid,
    output logic [7:0]                pix_r,
    output logic [7:0]                pix_g,
    output logic [7:0]                pix_b
);

    logic rd_valid;    // ram output holds the word asked for last cycle

    // requests before the first frame is stored are dropped
    assign rd_en = pix_req & stream_ready;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            rd_addr <= '0;
        end else if (!stream_ready) begin
            rd_addr <= '0;    // playback restarts at the first frame
        end else if (rd_en) begin
            if (rd_addr == RAM_ADDR_WIDTH'(RAM_DEPTH - 1))
                rd_addr <= '0;    // wrap over the three frames
            else
                rd_addr <= rd_addr + 1'b1;
        end
    end

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            rd_valid <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            pix_valid <= rd_valid;    // two cycles after pix_req
        end
    end

    // widen each field back to 8 bits
    // the top bits are repeated below so full scale stays full scale
    always_ff @(posedge rgb_clk) begin
        if (rd_valid) begin
            pix_r <= {rd_data.ch.red, rd_data.ch.red[4:2]};
            pix_g <= {rd_data.ch.green, rd_data.ch.green[5:4]};
            pix_b <= {rd_data.ch.blue, rd_data.ch.blue[4:2]};
        end
    end

endmodule

/* hdl/rgb_capture_top.sv */
module rgb_capture_top
    import rgb_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 32
) (
    input  logic        rgb_clk,
    input  logic        nrst,
    input  logic [23:0] rgb,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        sclk,
    input  logic        mosi,
    input  logic        cs_n,
    input  logic        pix_req,
    output logic        miso,
    output logic        stream_ready,
    output logic        pix_valid,
    output logic [7:0]  pix_r,
    output logic [7:0]  pix_g,
    output logic [7:0]  pix_b
);

    logic                      rgb_enable;
    logic [RAM_ADDR_WIDTH-1:0] wr_addr;
    pixel565_u                 wr_data;
    logic                      write_enable;
    logic                      rd_en;
    logic [RAM_ADDR_WIDTH-1:0] rd_addr;
    pixel565_u                 rd_data;

    // capture side
    rgb_logic #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) rgb_logic_i (
        .rgb_clk     (rgb_clk),
        .nrst        (nrst),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb_enable  (rgb_enable),
        .ram_addr    (wr_addr),
        .ram_data    (wr_data),
        .write_enable(write_enable),
        .stream_ready(stream_ready)
    );

    spi_ctrl spi_ctrl_i (
        .rgb_clk     (rgb_clk),
        .nrst        (nrst),
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_n        (cs_n),
        .stream_ready(stream_ready),
        .miso        (miso),
        .rgb_enable  (rgb_enable)
    );

    frame_ram #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) frame_ram_i (
        .rgb_clk(rgb_clk),
        .wr_en  (write_enable),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // playback side
    stream_reader #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) stream_reader_i (
        .rgb_clk     (rgb_clk),
        .nrst        (nrst),
        .stream_ready(stream_ready),
        .pix_req     (pix_req),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .pix_valid   (pix_valid),
        .pix_r       (pix_r),
        .pix_g       (pix_g),
        .pix_b       (pix_b)
    );

endmodule

/* testbench/tb_rgb_capture.sv */
module tb_rgb_capture
    import rgb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int SCLK_DIV = 4;                          // rgb_clk cycles per sclk half period
    localparam logic [31:0] SEED = 32'h2d74;
    localparam logic [23:0] PARTIAL_BASE = 24'hf00f0f;    // never expected on playback
    localparam logic [31:0] NO_RESPONSE = 32'h0100_0000;  // read record with no pix_valid

    logic        rgb_clk = 1'b0;
    logic        nrst, hsync, vsync, sclk, mosi, cs_n, pix_req;
    logic [23:0] rgb;
    logic        miso, stream_ready, pix_valid;
    logic [7:0]  pix_r, pix_g, pix_b;
    string       ops[$], names[$];
    logic [31:0] args[$], exps[$];
    int          error_count = 0;
    int          check_count = 0;
    int          limit_cycles = 0;    // watchdog length, stays 0 until the stim file is read
    int          rd_idx = 0;          // expected playback position

    rgb_capture_top rgb_capture_top_i (.*);

    always #(CLK_PERIOD / 2) rgb_clk = ~rgb_clk;

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge rgb_clk);
        $display("simulation timed out after %0d clock cycles", limit_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // source pixel rule, wraps at 24 bits
    function automatic logic [23:0] pixel_at(input logic [23:0] base, input int idx);
        return base + 24'(idx) * 24'h010203;
    endfunction

    // keep the top 5/6/5 bits, then refill the low bits from the top
    function automatic logic [23:0] expected_rgb(input logic [23:0] p);
        return {p[23:19], p[23:21], p[15:10], p[15:14], p[7:3], p[7:5]};
    endfunction

    function automatic int record_cycles(input string op, input logic [31:0] arg);
        if (op == "spi") return 20 * SCLK_DIV + 1;
        if (op == "frame") return IMAGE_SIZE + 4 * IMAGE_H + 7;
        if (op == "partial") return int'(arg) + 4 * (int'(arg) / IMAGE_W + 1) + 7;
        if (op == "read") return 5 * int'(arg) + 3;
        if (op == "wait") return int'(arg) + 1;
        return 1;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge rgb_clk);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", test_name, expected, actual);
            error_count++;
        end
    endtask

    // spi mode 0, msb first, miso sampled just before each rising sclk
    task automatic spi_transfer(input logic [7:0] cmd, output logic [7:0] status);
        status = '0;
        @(negedge rgb_clk);
        cs_n <= 1'b0;
        for (int b = 7; b >= 0; b--) begin
            mosi <= cmd[b];
            wait_cycles(SCLK_DIV);
            status = {status[6:0], miso};
            sclk <= 1'b1;
            wait_cycles(SCLK_DIV);
            sclk <= 1'b0;
        end
        wait_cycles(SCLK_DIV);
        cs_n <= 1'b1;
        wait_cycles(3 * SCLK_DIV);    // command lands a few cycles after deselect
    endtask

    // vblank first, then lines of IMAGE_W pixels each closed by 4 hsync low cycles
    task automatic drive_pixels(input logic [23:0] base, input int count);
        wait_cycles(1);
        vsync <= 1'b0;
        wait_cycles(6);
        for (int i = 0; i < count; i++) begin
            vsync <= 1'b1;
            hsync <= 1'b1;
            rgb <= pixel_at(base, i);
            wait_cycles(1);
            if (i % IMAGE_W == IMAGE_W - 1 || i == count - 1) begin
                hsync <= 1'b0;
                rgb <= '0;
                wait_cycles(4);
            end
        end
        vsync <= 1'b0;    // idle is vertical blanking
        hsync <= 1'b1;
        wait_cycles(1);
    endtask

    // pix_req strobes with random gaps, every response due two cycles after its request
    task automatic read_pixels(input string test_name, input int count, input logic [31:0] base);
        int         issued;
        int         gap;
        logic [1:0] due;    // requests one and two cycles back that expect data
        logic       want;
        issued = 0;
        gap = 0;
        due = '0;
        while (issued < count || due != 2'b00) begin
            @(negedge rgb_clk);
            if (due[1] && !pix_valid) begin
                $display("%s: no pix_valid two cycles after request %0d", test_name, rd_idx);
                error_count++;
            end else if (due[1]) begin
                check_value(test_name, 32'(expected_rgb(pixel_at(base[23:0], rd_idx))),
                            {8'h00, pix_r, pix_g, pix_b});
            end else if (pix_valid) begin
                $display("%s: pix_valid came without a matching request", test_name);
                error_count++;
            end
            if (due[1])
                rd_idx++;
            want = (issued < count) && (gap == 0);
            pix_req <= want;
            due = {due[0], want && (base != NO_RESPONSE)};
            if (want) begin
                issued++;
                gap = int'($urandom_range(3, 0));
            end else if (gap > 0) begin
                gap--;
            end
        end
        repeat (2) begin    // trailing quiet cycles
            @(negedge rgb_clk);
            pix_req <= 1'b0;
            if (pix_valid) begin
                $display("%s: stray pix_valid after the last request", test_name);
                error_count++;
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          errors_before;
        int          total_cycles;
        string       line, op, name;
        logic [31:0] arg, exp_val;
        logic [7:0]  status;
        nrst = 1'b0;
        rgb = '0;
        hsync = 1'b1;
        vsync = 1'b0;
        sclk = 1'b0;
        mosi = 1'b0;
        cs_n = 1'b1;
        pix_req = 1'b0;
        total_cycles = 0;
        void'($urandom(SEED));
        fd = $fopen("testbench/rgb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/rgb_stim.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h", op, name, arg, exp_val);
                    if (n == 4) begin
                        ops.push_back(op);
                        names.push_back(name);
                        args.push_back(arg);
                        exps.push_back(exp_val);
                        total_cycles += record_cycles(op, arg);
                    end
                end
            end
            $fclose(fd);
        end
        if (ops.size() == 0) begin
            $display("the stimulus file gave no records to run");
            error_count++;
        end
        limit_cycles = 2 * (total_cycles + 10);    // arms the watchdog
        wait_cycles(3);
        nrst <= 1'b1;
        wait_cycles(2);
        for (int i = 0; i < ops.size(); i++) begin
            errors_before = error_count;
            if (ops[i] == "spi") begin
                spi_transfer(args[i][7:0], status);
                if (args[i][7:0] == CMD_DISABLE)
                    rd_idx = 0;    // playback restarts once stream_ready drops
                check_value(names[i], exps[i], 32'(status));
            end else if (ops[i] == "read") begin
                read_pixels(names[i], int'(args[i]), exps[i]);
            end else if (ops[i] == "frame" || ops[i] == "partial" || ops[i] == "wait") begin
                if (ops[i] == "frame")
                    drive_pixels(args[i][23:0], IMAGE_SIZE);
                else if (ops[i] == "partial")
                    drive_pixels(PARTIAL_BASE, int'(args[i]));
                else
                    wait_cycles(int'(args[i]));
                check_value(names[i], exps[i], 32'(stream_ready));
            end else begin
                $display("unknown operation %s in record %s", ops[i], names[i]);
                error_count++;
            end
            $display("%-8s %-16s %s", ops[i], names[i],
                     (error_count == errors_before) ? "ok" : "failed");
        end
        $display("%0d tests, %0d checks, %0d errors", ops.size(), check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* testbench/rgb_stim.txt */
# columns: operation, test name, argument (hex), expected value (hex)
# spi: cmd/status byte, frame: base/ready, partial: pixels/ready, read: count/base, wait: cycles/ready
spi     status_reset    ff      00
read    read_idle       4       1000000
spi     enable          01      00
spi     status_enable   ff      40
partial partial_frame   3e8     0
wait    partial_idle    10      0
frame   frame_a         102030  1
spi     status_ready    ff      c0
read    read_a          c8      102030
frame   frame_b         a0b0c0  1
read    read_a_more     64      102030
spi     disable         00      c0
wait    disabled        4       0
spi     status_off      ff      00
spi     enable_again    01      00
spi     status_again    ff      40
wait    no_frame_yet    28      0
frame   frame_c         345678  1
read    read_c          50      345678

/* flist.f */
hdl/rgb_pkg.sv
hdl/rgb_logic.sv
hdl/spi_ctrl.sv
hdl/frame_ram.sv
hdl/stream_reader.sv
hdl/rgb_capture_top.sv
testbench/tb_rgb_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rgb capture testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rgb_capture -f flist.f -o tb_rgb_capture
./obj_dir/tb_rgb_capture | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
